/* hw/voice_cfg.svh */
// Bus widths, peer selectors and register reset values for the voice board bus
`ifndef VOICE_CFG_SVH
`define VOICE_CFG_SVH

// ----------------------------------------------------------
// Bus geometry
// ----------------------------------------------------------
`define VOICE_ADDR_W 15
`define VOICE_DATA_W 16
`define VOICE_GPIO_W 16

// ----------------------------------------------------------
// Peer selectors, top address bits
// ----------------------------------------------------------
`define VOICE_SEL_W    3
`define VOICE_SEL_CFG  3'b000
`define VOICE_SEL_GPIO 3'b100

// Configuration bank values
`define VOICE_VERSION        16'h000A
`define VOICE_GAIN_DEFAULT   16'd3
`define VOICE_VOLUME_DEFAULT 16'd15

`endif

/* hw/voice_pkg.sv */
// Bus word, pin vector, host index and peer select types for the voice board bus
`include "voice_cfg.svh"

package voice_pkg;

  // Shared bus payloads
  typedef logic [`VOICE_ADDR_W-1:0] bus_addr_t;
  typedef logic [`VOICE_DATA_W-1:0] bus_data_t;

  // GPIO pin vector
  typedef logic [`VOICE_GPIO_W-1:0] gpio_t;

  // One of the two hosts
  typedef logic host_idx_t;

  // Target of a decoded transfer
  typedef enum logic [1:0] {
    peer_cfg,
    peer_gpio,
    peer_none
  } peer_sel_e;

endpackage

/* hw/bus_arbiter.sv */
// Round-robin arbiter granting one of two hosts the shared register bus
`timescale 1ns/1ps

module bus_arbiter import voice_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  // Host 0
  input  logic      h0_cyc_i,
  input  logic      h0_stb_i,
  input  logic      h0_we_i,
  input  bus_addr_t h0_adr_i,
  input  bus_data_t h0_dat_i,
  output bus_data_t h0_dat_o,
  output logic      h0_ack_o,
  // Host 1
  input  logic      h1_cyc_i,
  input  logic      h1_stb_i,
  input  logic      h1_we_i,
  input  bus_addr_t h1_adr_i,
  input  bus_data_t h1_dat_i,
  output bus_data_t h1_dat_o,
  output logic      h1_ack_o,
  // Shared bus
  output logic      m_cyc_o,
  output logic      m_stb_o,
  output logic      m_we_o,
  output bus_addr_t m_adr_o,
  output bus_data_t m_wdat_o,
  input  bus_data_t m_rdat_i,
  input  logic      m_ack_i
);

  logic      h0_req;
  logic      h1_req;
  logic      busy_q;
  host_idx_t grant_q;
  host_idx_t last_q;
  host_idx_t pick;

  assign h0_req = h0_cyc_i & h0_stb_i;
  assign h1_req = h1_cyc_i & h1_stb_i;

  // Favour the host not served last when both ask
  always_comb begin
    if (h0_req && h1_req) begin
      pick = ~last_q;
    end else if (h1_req) begin
      pick = 1'b1;
    end else begin
      pick = 1'b0;
    end
  end

  // ----------------------------------------------------------
  // Grant state
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      grant_q <= 1'b0;
      last_q  <= 1'b1;
    end else if (!busy_q) begin
      if (h0_req || h1_req) begin
        busy_q  <= 1'b1;
        grant_q <= pick;
        last_q  <= pick;
      end
    end else if (m_ack_i) begin
      // Bus free again one cycle after the ack
      busy_q <= 1'b0;
    end
  end

  // Granted host onto the shared bus
  always_comb begin
    if (grant_q) begin
      m_cyc_o  = busy_q & h1_cyc_i;
      m_stb_o  = busy_q & h1_stb_i;
      m_we_o   = h1_we_i;
      m_adr_o  = h1_adr_i;
      m_wdat_o = h1_dat_i;
    end else begin
      m_cyc_o  = busy_q & h0_cyc_i;
      m_stb_o  = busy_q & h0_stb_i;
      m_we_o   = h0_we_i;
      m_adr_o  = h0_adr_i;
      m_wdat_o = h0_dat_i;
    end
  end

  // Responses go back to the granted host only
  assign h0_ack_o = busy_q & m_ack_i & (grant_q == 1'b0);
  assign h1_ack_o = busy_q & m_ack_i & (grant_q == 1'b1);
  assign h0_dat_o = (busy_q && grant_q == 1'b0) ? m_rdat_i : '0;
  assign h1_dat_o = (busy_q && grant_q == 1'b1) ? m_rdat_i : '0;

endmodule

/* hw/bus_decoder.sv */
// Address decoder routing shared bus transfers to the config bank or the GPIO block
`timescale 1ns/1ps
`include "voice_cfg.svh"

module bus_decoder import voice_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  // Shared bus from the arbiter
  input  logic      m_cyc_i,
  input  logic      m_stb_i,
  input  logic      m_we_i,
  input  bus_addr_t m_adr_i,
  input  bus_data_t m_wdat_i,
  output bus_data_t m_rdat_o,
  output logic      m_ack_o,
  // Peer side
  output logic      cfg_stb_o,
  output logic      gpio_stb_o,
  output bus_addr_t p_adr_o,
  output logic      p_we_o,
  output bus_data_t p_wdat_o,
  input  bus_data_t cfg_rdat_i,
  input  bus_data_t gpio_rdat_i,
  input  logic      cfg_ack_i,
  input  logic      gpio_ack_i
);

  logic [`VOICE_SEL_W-1:0] sel_bits;
  peer_sel_e               sel;
  logic                    req;
  logic                    none_ack_q;

  assign sel_bits = m_adr_i[`VOICE_ADDR_W-1 -: `VOICE_SEL_W];
  assign req      = m_cyc_i & m_stb_i;

  always_comb begin
    case (sel_bits)
      `VOICE_SEL_CFG:  sel = peer_cfg;
      `VOICE_SEL_GPIO: sel = peer_gpio;
      default:         sel = peer_none;
    endcase
  end

  // Strobe reaches the addressed peer only
  assign cfg_stb_o  = req & (sel == peer_cfg);
  assign gpio_stb_o = req & (sel == peer_gpio);
  assign p_adr_o    = m_adr_i;
  assign p_we_o     = m_we_i;
  assign p_wdat_o   = m_wdat_i;

  // Unmapped space answers by itself, one cycle after the strobe
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= req & (sel == peer_none) & ~none_ack_q;
    end
  end

  // Response mux
  always_comb begin
    case (sel)
      peer_cfg: begin
        m_rdat_o = cfg_rdat_i;
        m_ack_o  = cfg_ack_i;
      end
      peer_gpio: begin
        m_rdat_o = gpio_rdat_i;
        m_ack_o  = gpio_ack_i;
      end
      default: begin
        m_rdat_o = '0;
        m_ack_o  = none_ack_q;
      end
    endcase
  end

endmodule

/* hw/cfg_regs.sv */
// Configuration register bank with version, mic gain, DAC volume and DAC flags
`timescale 1ns/1ps
`include "voice_cfg.svh"

module cfg_regs import voice_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_addr_t adr_i,
  input  bus_data_t wdat_i,
  output bus_data_t rdat_o,
  output logic      ack_o,
  output bus_data_t gain_o,
  output bus_data_t volume_o,
  output logic      dac_mute_o,
  output logic      dac_hp_nspk_o
);

  // Word offsets
  localparam logic [1:0] OFS_VERSION = 2'd0;
  localparam logic [1:0] OFS_GAIN    = 2'd1;
  localparam logic [1:0] OFS_VOLUME  = 2'd2;
  localparam logic [1:0] OFS_FLAGS   = 2'd3;

  bus_data_t gain_q;
  bus_data_t volume_q;
  logic      mute_q;
  logic      hp_nspk_q;
  logic      ack_q;
  bus_data_t rdat_q;
  bus_data_t rd_mux;
  logic      access;

  assign access = stb_i & ~ack_q;

  always_comb begin
    case (adr_i[1:0])
      OFS_VERSION: rd_mux = `VOICE_VERSION;
      OFS_GAIN:    rd_mux = gain_q;
      OFS_VOLUME:  rd_mux = volume_q;
      OFS_FLAGS:   rd_mux = {{(`VOICE_DATA_W-2){1'b0}}, hp_nspk_q, mute_q};
      default:     rd_mux = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Control registers and ack
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      gain_q    <= `VOICE_GAIN_DEFAULT;
      volume_q  <= `VOICE_VOLUME_DEFAULT;
      mute_q    <= 1'b0;
      hp_nspk_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && we_i) begin
        // Version word is read-only
        case (adr_i[1:0])
          OFS_GAIN:   gain_q   <= wdat_i;
          OFS_VOLUME: volume_q <= wdat_i;
          OFS_FLAGS: begin
            mute_q    <= wdat_i[0];
            hp_nspk_q <= wdat_i[1];
          end
          default: ;
        endcase
      end
    end
  end

  // Read word captured with the ack
  always_ff @(posedge clk) begin
    if (access) begin
      rdat_q <= rd_mux;
    end
  end

  assign rdat_o        = rdat_q;
  assign ack_o         = ack_q;
  assign gain_o        = gain_q;
  assign volume_o      = volume_q;
  assign dac_mute_o    = mute_q;
  assign dac_hp_nspk_o = hp_nspk_q;

endmodule

/* hw/gpio_port.sv */
// GPIO block with direction, output and synchronized input registers
`timescale 1ns/1ps

module gpio_port import voice_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_addr_t adr_i,
  input  bus_data_t wdat_i,
  output bus_data_t rdat_o,
  output logic      ack_o,
  input  gpio_t     gpio_in_i,
  output gpio_t     gpio_out_o,
  output gpio_t     gpio_oe_o
);

  gpio_t     dir_q;
  gpio_t     out_q;
  gpio_t     in_meta_q;
  gpio_t     in_sync_q;
  logic      ack_q;
  bus_data_t rdat_q;
  logic      access;

  assign access = stb_i & ~ack_q;

  // Two-stage synchronizer on the pins
  always_ff @(posedge clk) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      dir_q <= '0;
      out_q <= '0;
    end else begin
      ack_q <= access;
      if (access && we_i && adr_i[1:0] == 2'd0) begin
        dir_q <= gpio_t'(wdat_i);
      end
      if (access && we_i && adr_i[1:0] == 2'd1) begin
        out_q <= gpio_t'(wdat_i);
      end
    end
  end

  // Offset 2 is the sampled input, offset 3 reads zero
  always_ff @(posedge clk) begin
    if (access) begin
      case (adr_i[1:0])
        2'd0:    rdat_q <= bus_data_t'(dir_q);
        2'd1:    rdat_q <= bus_data_t'(out_q);
        2'd2:    rdat_q <= bus_data_t'(in_sync_q);
        default: rdat_q <= '0;
      endcase
    end
  end

  assign rdat_o     = rdat_q;
  assign ack_o      = ack_q;
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

/* hw/voice_top.sv */
// Top level of the voice board register bus with arbiter, decoder and peers
`timescale 1ns/1ps

module voice_top import voice_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  // Host 0
  input  logic      h0_cyc_i,
  input  logic      h0_stb_i,
  input  logic      h0_we_i,
  input  bus_addr_t h0_adr_i,
  input  bus_data_t h0_dat_i,
  output bus_data_t h0_dat_o,
  output logic      h0_ack_o,
  // Host 1
  input  logic      h1_cyc_i,
  input  logic      h1_stb_i,
  input  logic      h1_we_i,
  input  bus_addr_t h1_adr_i,
  input  bus_data_t h1_dat_i,
  output bus_data_t h1_dat_o,
  output logic      h1_ack_o,
  // Pins and configuration outputs
  input  gpio_t     gpio_in_i,
  output gpio_t     gpio_out_o,
  output gpio_t     gpio_oe_o,
  output bus_data_t mic_gain_o,
  output bus_data_t dac_volume_o,
  output logic      dac_mute_o,
  output logic      dac_hp_nspk_o
);

  // ----------------------------------------------------------
  // Shared bus and peer wires
  // ----------------------------------------------------------
  logic      m_cyc;
  logic      m_stb;
  logic      m_we;
  bus_addr_t m_adr;
  bus_data_t m_wdat;
  bus_data_t m_rdat;
  logic      m_ack;
  logic      cfg_stb;
  logic      gpio_stb;
  bus_addr_t p_adr;
  logic      p_we;
  bus_data_t p_wdat;
  bus_data_t cfg_rdat;
  bus_data_t gpio_rdat;
  logic      cfg_ack;
  logic      gpio_ack;

  bus_arbiter i_arbiter (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .h0_cyc_i (h0_cyc_i),
    .h0_stb_i (h0_stb_i),
    .h0_we_i  (h0_we_i),
    .h0_adr_i (h0_adr_i),
    .h0_dat_i (h0_dat_i),
    .h0_dat_o (h0_dat_o),
    .h0_ack_o (h0_ack_o),
    .h1_cyc_i (h1_cyc_i),
    .h1_stb_i (h1_stb_i),
    .h1_we_i  (h1_we_i),
    .h1_adr_i (h1_adr_i),
    .h1_dat_i (h1_dat_i),
    .h1_dat_o (h1_dat_o),
    .h1_ack_o (h1_ack_o),
    .m_cyc_o  (m_cyc),
    .m_stb_o  (m_stb),
    .m_we_o   (m_we),
    .m_adr_o  (m_adr),
    .m_wdat_o (m_wdat),
    .m_rdat_i (m_rdat),
    .m_ack_i  (m_ack)
  );

  bus_decoder i_decoder (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .m_cyc_i     (m_cyc),
    .m_stb_i     (m_stb),
    .m_we_i      (m_we),
    .m_adr_i     (m_adr),
    .m_wdat_i    (m_wdat),
    .m_rdat_o    (m_rdat),
    .m_ack_o     (m_ack),
    .cfg_stb_o   (cfg_stb),
    .gpio_stb_o  (gpio_stb),
    .p_adr_o     (p_adr),
    .p_we_o      (p_we),
    .p_wdat_o    (p_wdat),
    .cfg_rdat_i  (cfg_rdat),
    .gpio_rdat_i (gpio_rdat),
    .cfg_ack_i   (cfg_ack),
    .gpio_ack_i  (gpio_ack)
  );

  // Config bank at 0x0000
  cfg_regs i_cfg (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stb_i         (cfg_stb),
    .we_i          (p_we),
    .adr_i         (p_adr),
    .wdat_i        (p_wdat),
    .rdat_o        (cfg_rdat),
    .ack_o         (cfg_ack),
    .gain_o        (mic_gain_o),
    .volume_o      (dac_volume_o),
    .dac_mute_o    (dac_mute_o),
    .dac_hp_nspk_o (dac_hp_nspk_o)
  );

  // GPIO block at 0x4000
  gpio_port i_gpio (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .stb_i      (gpio_stb),
    .we_i       (p_we),
    .adr_i      (p_adr),
    .wdat_i     (p_wdat),
    .rdat_o     (gpio_rdat),
    .ack_o      (gpio_ack),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o)
  );

endmodule

/* verif/voice_assertions.sv */
// Bound checker of the host and shared bus handshake rules at the arbiter
`timescale 1ns/1ps

module voice_assertions (
  input logic clk,
  input logic rst_n_i,
  input logic h0_stb_i,
  input logic h1_stb_i,
  input logic h0_ack_i,
  input logic h1_ack_i,
  input logic m_cyc_i,
  input logic m_stb_i,
  input logic m_ack_i
);

  // Ack only to one host at a time, and only to a host that is asking
  a_one_host_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(h0_ack_i && h1_ack_i) && (h0_stb_i || !h0_ack_i) && (h1_stb_i || !h1_ack_i))
    else $error("ack raised on both hosts or on a host without a strobe");

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_stb_i |-> m_cyc_i)
    else $error("shared strobe without cycle");

  // Peer acks reach the arbiter through the decoder
  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_ack_i |=> !m_ack_i)
    else $error("peer ack held longer than one cycle");

  a_h0_answered: assert property (@(posedge clk) disable iff (!rst_n_i)
    h0_stb_i |-> ##[0:16] h0_ack_i)
    else $error("host 0 strobe not answered within 16 cycles");

  a_h1_answered: assert property (@(posedge clk) disable iff (!rst_n_i)
    h1_stb_i |-> ##[0:16] h1_ack_i)
    else $error("host 1 strobe not answered within 16 cycles");

endmodule

/* verif/voice_tb.sv */
// Directed testbench for the voice board register bus with bus tasks, compare tasks and tests
`timescale 1ns/1ps

module voice_tb import voice_pkg::*; ();

  // Register map as seen by the hosts
  localparam bus_addr_t ADR_VERSION  = 15'h0000;
  localparam bus_addr_t ADR_GAIN     = 15'h0001;
  localparam bus_addr_t ADR_VOLUME   = 15'h0002;
  localparam bus_addr_t ADR_FLAGS    = 15'h0003;
  localparam bus_addr_t ADR_DIR      = 15'h4000;
  localparam bus_addr_t ADR_OUT      = 15'h4001;
  localparam bus_addr_t ADR_IN       = 15'h4002;
  localparam bus_addr_t ADR_UNMAPPED = 15'h2000;
  localparam bus_data_t VERSION_WORD = 16'h000A;
  localparam int        ACK_TIMEOUT  = 20;

  logic      clk;
  logic      rst_n_i;
  logic      h0_cyc_i;
  logic      h0_stb_i;
  logic      h0_we_i;
  bus_addr_t h0_adr_i;
  bus_data_t h0_dat_i;
  bus_data_t h0_dat_o;
  logic      h0_ack_o;
  logic      h1_cyc_i;
  logic      h1_stb_i;
  logic      h1_we_i;
  bus_addr_t h1_adr_i;
  bus_data_t h1_dat_i;
  bus_data_t h1_dat_o;
  logic      h1_ack_o;
  gpio_t     gpio_in_i;
  gpio_t     gpio_out_o;
  gpio_t     gpio_oe_o;
  bus_data_t mic_gain_o;
  bus_data_t dac_volume_o;
  logic      dac_mute_o;
  logic      dac_hp_nspk_o;

  int          errors;
  int          timeouts;
  int          checks;
  logic        last_acked;

  // Expected register contents
  bus_data_t exp_gain;
  bus_data_t exp_volume;
  gpio_t     exp_dir;
  gpio_t     exp_out;

  voice_top i_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .h0_cyc_i      (h0_cyc_i),
    .h0_stb_i      (h0_stb_i),
    .h0_we_i       (h0_we_i),
    .h0_adr_i      (h0_adr_i),
    .h0_dat_i      (h0_dat_i),
    .h0_dat_o      (h0_dat_o),
    .h0_ack_o      (h0_ack_o),
    .h1_cyc_i      (h1_cyc_i),
    .h1_stb_i      (h1_stb_i),
    .h1_we_i       (h1_we_i),
    .h1_adr_i      (h1_adr_i),
    .h1_dat_i      (h1_dat_i),
    .h1_dat_o      (h1_dat_o),
    .h1_ack_o      (h1_ack_o),
    .gpio_in_i     (gpio_in_i),
    .gpio_out_o    (gpio_out_o),
    .gpio_oe_o     (gpio_oe_o),
    .mic_gain_o    (mic_gain_o),
    .dac_volume_o  (dac_volume_o),
    .dac_mute_o    (dac_mute_o),
    .dac_hp_nspk_o (dac_hp_nspk_o)
  );

  bind bus_arbiter voice_assertions i_assertions (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .h0_stb_i (h0_stb_i),
    .h1_stb_i (h1_stb_i),
    .h0_ack_i (h0_ack_o),
    .h1_ack_i (h1_ack_o),
    .m_cyc_i  (m_cyc_o),
    .m_stb_i  (m_stb_o),
    .m_ack_i  (m_ack_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // Bus tasks, called on a rising edge
  // ----------------------------------------------------------
  task automatic set_request(input host_idx_t host, input logic req, input logic we,
                             input bus_addr_t adr, input bus_data_t dat);
    if (host) begin
      h1_cyc_i <= req;
      h1_stb_i <= req;
      h1_we_i  <= we;
      h1_adr_i <= adr;
      h1_dat_i <= dat;
    end else begin
      h0_cyc_i <= req;
      h0_stb_i <= req;
      h0_we_i  <= we;
      h0_adr_i <= adr;
      h0_dat_i <= dat;
    end
  endtask

  task automatic run_transfer(input host_idx_t host, input logic we, input bus_addr_t adr,
                              input bus_data_t wdat, output bus_data_t rdat);
    int   cycles;
    logic acked;
    cycles = 0;
    acked  = 1'b0;
    rdat   = '0;
    set_request(host, 1'b1, we, adr, wdat);
    // Request stays up until the host sees its ack
    while (!acked && cycles < ACK_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      acked = host ? h1_ack_o : h0_ack_o;
      rdat  = host ? h1_dat_o : h0_dat_o;
    end
    set_request(host, 1'b0, 1'b0, '0, '0);
    last_acked = acked;
    if (!acked) begin
      timeouts++;
      $display("timeout: host %0d got no ack for address %h", host, adr);
    end
  endtask

  task automatic bus_write(input host_idx_t host, input bus_addr_t adr, input bus_data_t dat);
    bus_data_t unused;
    run_transfer(host, 1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input host_idx_t host, input bus_addr_t adr, output bus_data_t dat);
    run_transfer(host, 1'b0, adr, '0, dat);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic reset_defaults();
    bus_data_t rd;
    bus_read(1'b0, ADR_VERSION, rd);
    check_data("version", rd, VERSION_WORD);
    bus_read(1'b0, ADR_GAIN, rd);
    check_data("gain", rd, 16'd3);
    bus_read(1'b0, ADR_VOLUME, rd);
    check_data("volume", rd, 16'd15);
    bus_read(1'b0, ADR_FLAGS, rd);
    check_data("flags", rd, 16'h0000);
    check_data("mic_gain_o", mic_gain_o, 16'd3);
    check_data("dac_volume_o", dac_volume_o, 16'd15);
    check_bit("dac_mute_o", dac_mute_o, 1'b0);
    check_bit("dac_hp_nspk_o", dac_hp_nspk_o, 1'b0);
    check_gpio("gpio_oe_o", gpio_oe_o, '0);
    exp_gain   = 16'd3;
    exp_volume = 16'd15;
    exp_dir    = '0;
    exp_out    = '0;
  endtask

  task automatic config_writes();
    bus_data_t rd;
    exp_gain   = bus_data_t'($urandom());
    exp_volume = bus_data_t'($urandom());
    bus_write(1'b1, ADR_GAIN, exp_gain);
    bus_write(1'b1, ADR_VOLUME, exp_volume);
    bus_write(1'b1, ADR_FLAGS, 16'h0003);
    bus_read(1'b1, ADR_GAIN, rd);
    check_data("gain", rd, exp_gain);
    bus_read(1'b1, ADR_VOLUME, rd);
    check_data("volume", rd, exp_volume);
    bus_read(1'b1, ADR_FLAGS, rd);
    check_data("flags", rd, 16'h0003);
    check_data("mic_gain_o", mic_gain_o, exp_gain);
    check_data("dac_volume_o", dac_volume_o, exp_volume);
    check_bit("dac_mute_o", dac_mute_o, 1'b1);
    check_bit("dac_hp_nspk_o", dac_hp_nspk_o, 1'b1);
    // Version word is read-only
    bus_write(1'b1, ADR_VERSION, ~VERSION_WORD);
    bus_read(1'b1, ADR_VERSION, rd);
    check_data("version", rd, VERSION_WORD);
  endtask

  task automatic gpio_access();
    bus_data_t rd;
    gpio_t     pins;
    exp_dir = gpio_t'($urandom());
    exp_out = gpio_t'($urandom());
    pins    = gpio_t'($urandom());
    bus_write(1'b0, ADR_DIR, bus_data_t'(exp_dir));
    bus_write(1'b0, ADR_OUT, bus_data_t'(exp_out));
    check_gpio("gpio_oe_o", gpio_oe_o, exp_dir);
    check_gpio("gpio_out_o", gpio_out_o, exp_out);
    bus_read(1'b0, ADR_DIR, rd);
    check_data("gpio direction", rd, bus_data_t'(exp_dir));
    bus_read(1'b0, ADR_OUT, rd);
    check_data("gpio output", rd, bus_data_t'(exp_out));
    // Pins settle through the two-stage synchronizer
    gpio_in_i <= pins;
    repeat (4) @(posedge clk);
    bus_read(1'b1, ADR_IN, rd);
    check_data("gpio input", rd, bus_data_t'(pins));
  endtask

  task automatic unmapped_access();
    bus_data_t rd;
    bus_read(1'b0, ADR_UNMAPPED, rd);
    check_bit("unmapped ack", last_acked, 1'b1);
    check_data("unmapped read", rd, 16'h0000);
    bus_write(1'b0, ADR_UNMAPPED + 15'd1, bus_data_t'($urandom()));
    bus_write(1'b1, ADR_UNMAPPED, bus_data_t'($urandom()));
    bus_read(1'b0, ADR_GAIN, rd);
    check_data("gain", rd, exp_gain);
    bus_read(1'b0, ADR_VOLUME, rd);
    check_data("volume", rd, exp_volume);
    check_gpio("gpio_oe_o", gpio_oe_o, exp_dir);
    check_gpio("gpio_out_o", gpio_out_o, exp_out);
  endtask

  task automatic contention();
    bus_data_t rd;
    exp_gain   = bus_data_t'($urandom());
    exp_volume = bus_data_t'($urandom());
    fork
      bus_write(1'b0, ADR_GAIN, exp_gain);
      bus_write(1'b1, ADR_VOLUME, exp_volume);
    join
    bus_read(1'b1, ADR_GAIN, rd);
    check_data("gain", rd, exp_gain);
    bus_read(1'b0, ADR_VOLUME, rd);
    check_data("volume", rd, exp_volume);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(58865));
    errors     = 0;
    timeouts   = 0;
    checks     = 0;
    last_acked = 1'b0;
    rst_n_i    = 1'b0;
    h0_cyc_i   = 1'b0;
    h0_stb_i   = 1'b0;
    h0_we_i    = 1'b0;
    h0_adr_i   = '0;
    h0_dat_i   = '0;
    h1_cyc_i   = 1'b0;
    h1_stb_i   = 1'b0;
    h1_we_i    = 1'b0;
    h1_adr_i   = '0;
    h1_dat_i   = '0;
    gpio_in_i  = '0;
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);
    reset_defaults();
    config_writes();
    gpio_access();
    unmapped_access();
    contention();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hw
hw/voice_pkg.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/cfg_regs.sv
hw/gpio_port.sv
hw/voice_top.sv
verif/voice_assertions.sv
verif/voice_tb.sv

/* Bender.yml */
package:
  name: voice_bus

sources:
  - include_dirs:
      - hw
    files:
      - hw/voice_pkg.sv
      - hw/bus_arbiter.sv
      - hw/bus_decoder.sv
      - hw/cfg_regs.sv
      - hw/gpio_port.sv
      - hw/voice_top.sv
  - target: test
    files:
      - verif/voice_assertions.sv
      - verif/voice_tb.sv
